// ==== rtl/rv_decode_pkg.sv ====
package rv_decode_pkg;

    localparam int XLEN_INST      = 32;
    localparam int OPCODE_W       = 7;

    // entries in the execute input buffer
    localparam int DECODE_CREDITS = 4;
    localparam int CREDIT_W       = 3;

    // base opcodes, bits 6:0 of the instruction
    localparam logic [OPCODE_W-1:0] OPC_LOAD      = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPC_STORE     = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OPC_JAL       = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OPC_JALR      = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OPC_LUI       = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [OPCODE_W-1:0] OPC_OP        = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OPC_OP_32     = 7'b0111011;
    localparam logic [OPCODE_W-1:0] OPC_SYSTEM    = 7'b1110011;

    localparam logic [11:0] MRET_FUNCT12 = 12'h302;

    typedef logic [XLEN_INST-1:0] inst_t;

    typedef enum logic [3:0] {
        CLS_NONE, CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH, CLS_LOAD,
        CLS_STORE, CLS_ALU_IMM, CLS_SHIFT_IMM, CLS_ALU_REG, CLS_SHIFT_REG, CLS_SYSTEM
    } inst_class_t;

    typedef enum logic [2:0] {
        ALU_NONE = 3'd0, ALU_ADD = 3'd3, ALU_SUB = 3'd4,
        ALU_XOR = 3'd5, ALU_OR = 3'd6, ALU_AND = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {SLT_NONE, SLT_SIGNED, SLT_UNSIGNED} slt_kind_t;

    // bit 0 marks a left shift only together with bit 2 clear
    typedef enum logic [2:0] {
        SH_NONE = 3'd0, SLL = 3'd1, SLLW = 3'd3, SRL = 3'd5,
        SRLW = 3'd7, SRA = 3'd4, SRAW = 3'd6
    } shift_kind_t;

    typedef enum logic [2:0] {
        CMP_NONE = 3'd0, BEQ = 3'd2, BNE = 3'd3, BLT = 3'd4,
        BLTU = 3'd5, BGE = 3'd6, BGEU = 3'd7
    } cmp_kind_t;

    typedef enum logic [2:0] {
        LD_NONE = 3'd0, LB = 3'd1, LH = 3'd2, LW = 3'd3,
        LD = 3'd4, LBU = 3'd5, LHU = 3'd6, LWU = 3'd7
    } load_kind_t;

    typedef enum logic [2:0] {
        ST_NONE = 3'd0, SB = 3'd4, SH = 3'd5, SW = 3'd6, SD = 3'd7
    } store_kind_t;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0, IMM_CSR = 3'd1, IMM_SHAMT = 3'd2, IMM_S = 3'd3,
        IMM_U = 3'd4, IMM_J = 3'd5, IMM_I = 3'd6, IMM_B = 3'd7
    } imm_type_t;

    typedef struct packed {
        logic rs1_en;
        logic rs2_en;
        logic rd_en;
        logic jump_base_pc;
    } reg_use_t;

    typedef struct packed {
        alu_op_t     op;
        logic        src_imm;
        logic        is_word;
        slt_kind_t   slt;
        shift_kind_t shift;
        logic        shift_num_src;
    } alu_ctrl_t;

    typedef struct packed {
        load_kind_t  load;
        store_kind_t store;
    } mem_ctrl_t;

    typedef struct packed {
        cmp_kind_t  cmp;
        // funct3 of a csr instruction, 3'b100 otherwise
        logic [2:0] csr_ctrl;
        logic       ecall;
        logic       ebreak;
        logic       mret;
    } sys_ctrl_t;

    typedef struct packed {
        imm_type_t imm;
        reg_use_t  reg_use;
        alu_ctrl_t alu;
        mem_ctrl_t mem;
        sys_ctrl_t sys;
    } decode_ctrl_t;

endpackage

// ==== rtl/opcode_classifier.sv ====
`timescale 1ns/1ps

module opcode_classifier (
    input  rv_decode_pkg::inst_t       inst_i,
    output rv_decode_pkg::inst_class_t class_o,
    output rv_decode_pkg::reg_use_t    reg_use_o,
    output rv_decode_pkg::imm_type_t   imm_type_o
);
    import rv_decode_pkg::*;

    logic [OPCODE_W-1:0] opcode;
    logic [2:0]          funct3;
    logic                is_shift;

    assign opcode   = inst_i[OPCODE_W-1:0];
    assign funct3   = inst_i[14:12];
    assign is_shift = (funct3[1:0] == 2'b01);

    always_comb begin
        case (opcode)
            OPC_LUI:                   class_o = CLS_LUI;
            OPC_AUIPC:                 class_o = CLS_AUIPC;
            OPC_JAL:                   class_o = CLS_JAL;
            OPC_JALR:                  class_o = CLS_JALR;
            OPC_BRANCH:                class_o = CLS_BRANCH;
            OPC_LOAD:                  class_o = CLS_LOAD;
            OPC_STORE:                 class_o = CLS_STORE;
            OPC_OP_IMM, OPC_OP_IMM_32: class_o = is_shift ? CLS_SHIFT_IMM : CLS_ALU_IMM;
            OPC_OP, OPC_OP_32:         class_o = is_shift ? CLS_SHIFT_REG : CLS_ALU_REG;
            OPC_SYSTEM:                class_o = CLS_SYSTEM;
            default:                   class_o = CLS_NONE;
        endcase
    end

    always_comb begin
        reg_use_o  = '0;
        imm_type_o = IMM_NONE;
        case (class_o)
            CLS_LUI, CLS_AUIPC: begin
                reg_use_o.rd_en = 1'b1;
                imm_type_o      = IMM_U;
            end
            CLS_JAL: begin
                reg_use_o.rd_en = 1'b1;
                imm_type_o      = IMM_J;
            end
            CLS_JALR: begin
                reg_use_o = '{rs1_en: 1'b1, rs2_en: 1'b0, rd_en: 1'b1, jump_base_pc: 1'b1};
                imm_type_o = IMM_I;
            end
            CLS_BRANCH: begin
                reg_use_o.rs1_en = 1'b1;
                reg_use_o.rs2_en = 1'b1;
                imm_type_o       = IMM_B;
            end
            CLS_LOAD, CLS_ALU_IMM: begin
                reg_use_o.rs1_en = 1'b1;
                reg_use_o.rd_en  = 1'b1;
                imm_type_o       = IMM_I;
            end
            CLS_STORE: begin
                reg_use_o.rs1_en = 1'b1;
                reg_use_o.rs2_en = 1'b1;
                imm_type_o       = IMM_S;
            end
            CLS_SHIFT_IMM: begin
                reg_use_o.rs1_en = 1'b1;
                reg_use_o.rd_en  = 1'b1;
                imm_type_o       = IMM_SHAMT;
            end
            CLS_ALU_REG, CLS_SHIFT_REG: begin
                reg_use_o.rs1_en = 1'b1;
                reg_use_o.rs2_en = 1'b1;
                reg_use_o.rd_en  = 1'b1;
            end
            CLS_SYSTEM: begin
                // csrrw/csrrs/csrrc read rs1 but the immediate forms do not
                reg_use_o.rs1_en = ~funct3[2] & (funct3[1:0] != 2'b00);
                reg_use_o.rd_en  = 1'b1;
                imm_type_o       = IMM_CSR;
            end
            default: begin
                reg_use_o  = '0;
                imm_type_o = IMM_NONE;
            end
        endcase
    end

endmodule

// ==== rtl/alu_field_decoder.sv ====
`timescale 1ns/1ps

module alu_field_decoder (
    input  rv_decode_pkg::inst_t       inst_i,
    input  rv_decode_pkg::inst_class_t class_i,
    output rv_decode_pkg::alu_ctrl_t   alu_o
);
    import rv_decode_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       word;
    logic       is_alu;
    logic       f7_zero;
    logic       f7_alt;
    logic       imm_form;
    logic       arith_ok;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    // opcode bit 3 separates the 32-bit word forms
    assign word   = inst_i[3];

    assign is_alu = (class_i == CLS_ALU_IMM) || (class_i == CLS_SHIFT_IMM) ||
                    (class_i == CLS_ALU_REG) || (class_i == CLS_SHIFT_REG);

    // 64-bit immediate shifts carry shamt bit 5 in funct7 bit 0
    assign f7_zero = (class_i == CLS_SHIFT_IMM && !word) ? (funct7[6:1] == 6'b000000)
                                                         : (funct7 == 7'b0000000);
    assign f7_alt  = (class_i == CLS_SHIFT_IMM && !word) ? (funct7[6:1] == 6'b010000)
                                                         : (funct7 == 7'b0100000);

    assign imm_form = (class_i == CLS_ALU_IMM);

    // funct7 is immediate bits for the I forms, only sub uses the alternate code
    // word forms only have add and sub
    assign arith_ok = (imm_form || f7_zero || (funct3 == 3'b000 && f7_alt)) &&
                      (!word || funct3 == 3'b000);

    always_comb begin
        alu_o         = '0;
        alu_o.is_word = is_alu & word;
        case (class_i)
            CLS_AUIPC, CLS_LOAD, CLS_STORE: begin
                alu_o.op      = ALU_ADD;
                alu_o.src_imm = 1'b1;
            end
            CLS_ALU_IMM, CLS_ALU_REG: begin
                alu_o.src_imm = imm_form;
                if (arith_ok) begin
                    case (funct3)
                        3'b000: alu_o.op = (!imm_form && f7_alt) ? ALU_SUB : ALU_ADD;
                        3'b010: begin
                            alu_o.op  = ALU_SUB;
                            alu_o.slt = SLT_SIGNED;
                        end
                        3'b011: begin
                            alu_o.op  = ALU_SUB;
                            alu_o.slt = SLT_UNSIGNED;
                        end
                        3'b100:  alu_o.op = ALU_XOR;
                        3'b110:  alu_o.op = ALU_OR;
                        3'b111:  alu_o.op = ALU_AND;
                        default: alu_o.op = ALU_NONE;
                    endcase
                end
            end
            CLS_SHIFT_IMM, CLS_SHIFT_REG: begin
                alu_o.shift_num_src = (class_i == CLS_SHIFT_IMM);
                if (funct3 == 3'b001 && f7_zero) begin
                    alu_o.shift = word ? SLLW : SLL;
                end else if (funct3 == 3'b101 && f7_zero) begin
                    alu_o.shift = word ? SRLW : SRL;
                end else if (funct3 == 3'b101 && f7_alt) begin
                    alu_o.shift = word ? SRAW : SRA;
                end
            end
            default: alu_o.op = ALU_NONE;
        endcase
    end

endmodule

// ==== rtl/mem_field_decoder.sv ====
`timescale 1ns/1ps

module mem_field_decoder (
    input  rv_decode_pkg::inst_t       inst_i,
    input  rv_decode_pkg::inst_class_t class_i,
    output rv_decode_pkg::mem_ctrl_t   mem_o
);
    import rv_decode_pkg::*;

    logic [2:0] funct3;

    assign funct3 = inst_i[14:12];

    // load width and sign
    always_comb begin
        mem_o.load = LD_NONE;
        if (class_i == CLS_LOAD) begin
            case (funct3)
                3'b000:  mem_o.load = LB;
                3'b001:  mem_o.load = LH;
                3'b010:  mem_o.load = LW;
                3'b011:  mem_o.load = LD;
                3'b100:  mem_o.load = LBU;
                3'b101:  mem_o.load = LHU;
                3'b110:  mem_o.load = LWU;
                // no unsigned doubleword load
                default: mem_o.load = LD_NONE;
            endcase
        end
    end

    // store width
    always_comb begin
        mem_o.store = ST_NONE;
        if (class_i == CLS_STORE) begin
            case (funct3)
                3'b000:  mem_o.store = SB;
                3'b001:  mem_o.store = SH;
                3'b010:  mem_o.store = SW;
                3'b011:  mem_o.store = SD;
                default: mem_o.store = ST_NONE;
            endcase
        end
    end

endmodule

// ==== rtl/branch_sys_decoder.sv ====
`timescale 1ns/1ps

module branch_sys_decoder (
    input  rv_decode_pkg::inst_t       inst_i,
    input  rv_decode_pkg::inst_class_t class_i,
    output rv_decode_pkg::sys_ctrl_t   sys_o
);
    import rv_decode_pkg::*;

    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic        is_system;
    logic        trap_form;

    assign funct3    = inst_i[14:12];
    assign funct12   = inst_i[31:20];
    assign is_system = (class_i == CLS_SYSTEM);

    // rd, funct3 and rs1 all zero
    assign trap_form = is_system && (inst_i[19:7] == 13'b0);

    // branch compare
    always_comb begin
        sys_o.cmp = CMP_NONE;
        if (class_i == CLS_BRANCH) begin
            case (funct3)
                3'b000:  sys_o.cmp = BEQ;
                3'b001:  sys_o.cmp = BNE;
                3'b100:  sys_o.cmp = BLT;
                3'b101:  sys_o.cmp = BGE;
                3'b110:  sys_o.cmp = BLTU;
                3'b111:  sys_o.cmp = BGEU;
                default: sys_o.cmp = CMP_NONE;
            endcase
        end
    end

    // execute reads csr op and operand kind straight from funct3
    assign sys_o.csr_ctrl = is_system ? funct3 : 3'b100;

    assign sys_o.ecall  = trap_form && (funct12 == 12'h000);
    assign sys_o.ebreak = trap_form && (funct12 == 12'h001);
    assign sys_o.mret   = trap_form && (funct12 == MRET_FUNCT12);

endmodule

// ==== rtl/decode_credit_ctrl.sv ====
`timescale 1ns/1ps

module decode_credit_ctrl (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       inst_valid_i,
    output logic                       inst_ready_o,
    input  rv_decode_pkg::decode_ctrl_t ctrl_i,
    input  logic                       credit_return_i,
    output logic                       ctrl_valid_o,
    output rv_decode_pkg::decode_ctrl_t ctrl_o
);
    import rv_decode_pkg::*;

    // free entries in the execute input buffer
    logic [CREDIT_W-1:0] credit_cnt;
    logic                accept;
    decode_ctrl_t        ctrl_q;

    assign inst_ready_o = (credit_cnt != '0);
    assign accept       = inst_valid_i & inst_ready_o;

    // an accept spends a credit and a return gives one back
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt <= CREDIT_W'(DECODE_CREDITS);
        end else if (accept && !credit_return_i) begin
            credit_cnt <= credit_cnt - CREDIT_W'(1);
        end else if (!accept && credit_return_i) begin
            credit_cnt <= credit_cnt + CREDIT_W'(1);
        end
    end

    // one cycle valid per accepted instruction
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_valid_o <= 1'b0;
        end else begin
            ctrl_valid_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            ctrl_q <= ctrl_i;
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

// ==== rtl/rv_id_stage.sv ====
`timescale 1ns/1ps

module rv_id_stage (
    input  logic                        clk_i,
    input  logic                        arst_n_i,

    // fetch side
    input  logic                        inst_valid_i,
    input  rv_decode_pkg::inst_t        inst_i,
    output logic                        inst_ready_o,

    // execute side
    input  logic                        credit_return_i,
    output logic                        ctrl_valid_o,
    output rv_decode_pkg::decode_ctrl_t ctrl_o
);
    import rv_decode_pkg::*;

    inst_class_t  inst_class;
    reg_use_t     reg_use;
    imm_type_t    imm_type;
    alu_ctrl_t    alu_ctrl;
    mem_ctrl_t    mem_ctrl;
    sys_ctrl_t    sys_ctrl;
    decode_ctrl_t dec_ctrl;

    opcode_classifier opcode_classifier_inst (
        .inst_i     (inst_i),
        .class_o    (inst_class),
        .reg_use_o  (reg_use),
        .imm_type_o (imm_type)
    );

    alu_field_decoder alu_field_decoder_inst (
        .inst_i  (inst_i),
        .class_i (inst_class),
        .alu_o   (alu_ctrl)
    );

    mem_field_decoder mem_field_decoder_inst (
        .inst_i  (inst_i),
        .class_i (inst_class),
        .mem_o   (mem_ctrl)
    );

    branch_sys_decoder branch_sys_decoder_inst (
        .inst_i  (inst_i),
        .class_i (inst_class),
        .sys_o   (sys_ctrl)
    );

    // combined decode word
    assign dec_ctrl = '{
        imm:     imm_type,
        reg_use: reg_use,
        alu:     alu_ctrl,
        mem:     mem_ctrl,
        sys:     sys_ctrl
    };

    decode_credit_ctrl decode_credit_ctrl_inst (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .inst_valid_i    (inst_valid_i),
        .inst_ready_o    (inst_ready_o),
        .ctrl_i          (dec_ctrl),
        .credit_return_i (credit_return_i),
        .ctrl_valid_o    (ctrl_valid_o),
        .ctrl_o          (ctrl_o)
    );

endmodule

// ==== tests/rv_id_stage_assertions.sv ====
`timescale 1ns/1ps

module rv_id_stage_assertions (
    input logic clk_i,
    input logic arst_n_i,
    input logic inst_valid_i,
    input logic inst_ready_o,
    input logic credit_return_i,
    input logic ctrl_valid_o
);
    import rv_decode_pkg::*;

    logic [CREDIT_W:0] credit_model;
    logic              accept;

    assign accept = inst_valid_i & inst_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_model <= (CREDIT_W + 1)'(DECODE_CREDITS);
        end else begin
            credit_model <= credit_model - (CREDIT_W + 1)'(accept)
                            + (CREDIT_W + 1)'(credit_return_i);
        end
    end

    ready_follows_credits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        inst_ready_o == (credit_model != 0)) else $error("ready does not follow credits");

    credits_bounded: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        credit_model <= DECODE_CREDITS) else $error("credit count above buffer size");

    valid_after_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        accept |=> ctrl_valid_o) else $error("no output one cycle after accept");

    no_valid_without_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !accept |=> !ctrl_valid_o) else $error("output valid without accept");

endmodule

// ==== tests/tb_rv_id_stage.sv ====
`timescale 1ns/1ps

module tb_rv_id_stage;
    import rv_decode_pkg::*;

    typedef struct packed {
        inst_t        inst;
        decode_ctrl_t exp;
        logic         ret;
    } row_t;

    localparam mem_ctrl_t  MN = {LD_NONE, ST_NONE};
    localparam sys_ctrl_t  SN = {CMP_NONE, 3'b100, 3'b000};
    localparam load_kind_t LK [8] = '{LB, LH, LW, LD, LBU, LHU, LWU, LD_NONE};
    localparam store_kind_t SK [5] = '{SB, SH, SW, SD, ST_NONE};
    localparam cmp_kind_t  CK [8] = '{BEQ, BNE, CMP_NONE, CMP_NONE, BLT, BGE, BLTU, BGEU};

    logic         clk_i, arst_n_i, inst_valid_i, inst_ready_o, credit_return_i, ctrl_valid_o;
    inst_t        inst_i;
    decode_ctrl_t ctrl_o, cur_exp, exp_word;
    row_t         rows[$];
    decode_ctrl_t exp_q[$];
    int           cyc_q[$];
    int           cyc = 0, credits = DECODE_CREDITS, occ = 0, errors = 0, checks = 0;
    logic         hold = 1'b1, cur_ret = 1'b0, built = 1'b0;

    rv_id_stage rv_id_stage_inst (.*);

    bind rv_id_stage rv_id_stage_assertions rv_id_stage_assertions_inst (.*);

    // rs1 = x1 and rd = x3 in every encoded word
    function automatic inst_t enc(logic [6:0] f7, logic [4:0] rs2, logic [2:0] f3,
                                  logic [6:0] opc);
        return {f7, rs2, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic alu_ctrl_t alu(alu_op_t op, logic src, logic word, slt_kind_t slt,
                                      shift_kind_t sh, logic shn);
        return {op, src, word, slt, sh, shn};
    endfunction

    task automatic row(inst_t inst, imm_type_t imm, logic [3:0] regs, alu_ctrl_t a,
                       mem_ctrl_t m, sys_ctrl_t s);
        rows.push_back({inst, imm, regs, a, m, s, 1'(rows.size() % 4 != 3)});
    endtask

    task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cyc <= cyc + 1;

    // execute side freeing buffer entries with random gaps
    initial begin
        credit_return_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            credit_return_i = !hold && (occ > 0) && (cur_ret || ($urandom % 3 == 0));
        end
    end

    // scoreboard and credit tracking sampled mid cycle
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (ctrl_valid_o) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: output valid with no accepted instruction", $time);
                end else begin
                    exp_word = exp_q.pop_front();
                    check_value("decode word", 64'(ctrl_o), 64'(exp_word));
                    check_value("output cycle", 64'(cyc), 64'(cyc_q.pop_front()));
                end
                occ++;
            end
            check_value("inst_ready_o", 64'(inst_ready_o), 64'(credits != 0));
            if (inst_valid_i && inst_ready_o) begin
                exp_q.push_back(cur_exp);
                cyc_q.push_back(cyc + 1);
                credits--;
            end
            if (credit_return_i) begin
                credits++;
                occ--;
            end
        end
    end

    initial begin
        wait (built);
        repeat (rows.size() * 40) @(posedge clk_i);
        $display("ERROR: watchdog expired before all instructions were decoded");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(12047));
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        cur_exp      = '0;
        row(enc(7'h00, 5'd2, 3'd0, OPC_OP), IMM_NONE, 4'b1110,
            alu(ALU_ADD, 0, 0, SLT_NONE, SH_NONE, 0), MN, SN);
        row(enc(7'h20, 5'd2, 3'd0, OPC_OP), IMM_NONE, 4'b1110,
            alu(ALU_SUB, 0, 0, SLT_NONE, SH_NONE, 0), MN, SN);
        row(enc(7'h7f, 5'h1d, 3'd2, OPC_OP_IMM), IMM_I, 4'b1010,
            alu(ALU_SUB, 1, 0, SLT_SIGNED, SH_NONE, 0), MN, SN);
        row(enc(7'h7f, 5'h1d, 3'd3, OPC_OP_IMM), IMM_I, 4'b1010,
            alu(ALU_SUB, 1, 0, SLT_UNSIGNED, SH_NONE, 0), MN, SN);
        row(enc(7'h00, 5'd5, 3'd4, OPC_OP_IMM), IMM_I, 4'b1010,
            alu(ALU_XOR, 1, 0, SLT_NONE, SH_NONE, 0), MN, SN);
        // srai by 33 with shamt bit 5 in funct7 bit 0
        row(enc(7'h21, 5'd1, 3'd5, OPC_OP_IMM), IMM_SHAMT, 4'b1010,
            alu(ALU_NONE, 0, 0, SLT_NONE, SRA, 1), MN, SN);
        row(enc(7'h20, 5'd5, 3'd5, OPC_OP_IMM_32), IMM_SHAMT, 4'b1010,
            alu(ALU_NONE, 0, 1, SLT_NONE, SRAW, 1), MN, SN);
        row(enc(7'h00, 5'd2, 3'd1, OPC_OP_32), IMM_NONE, 4'b1110,
            alu(ALU_NONE, 0, 1, SLT_NONE, SLLW, 0), MN, SN);
        row(enc(7'h01, 5'd2, 3'd0, OPC_OP), IMM_NONE, 4'b1110, '0, MN, SN);
        for (int f = 0; f < 8; f++)
            row(enc(7'h00, 5'd8, 3'(f), OPC_LOAD), IMM_I, 4'b1010,
                alu(ALU_ADD, 1, 0, SLT_NONE, SH_NONE, 0), {LK[f], ST_NONE}, SN);
        for (int f = 0; f < 5; f++)
            row(enc(7'h00, 5'd2, 3'(f), OPC_STORE), IMM_S, 4'b1100,
                alu(ALU_ADD, 1, 0, SLT_NONE, SH_NONE, 0), {LD_NONE, SK[f]}, SN);
        for (int f = 0; f < 8; f++)
            row(enc(7'h00, 5'd2, 3'(f), OPC_BRANCH), IMM_B, 4'b1100, '0, MN,
                {CK[f], 3'b100, 3'b000});
        row(enc(7'h00, 5'd16, 3'd0, OPC_JAL), IMM_J, 4'b0010, '0, MN, SN);
        row(enc(7'h00, 5'd16, 3'd0, OPC_JALR), IMM_I, 4'b1011, '0, MN, SN);
        row(32'h00000073, IMM_CSR, 4'b0010, '0, MN, {CMP_NONE, 3'b000, 3'b100});
        row(32'h00100073, IMM_CSR, 4'b0010, '0, MN, {CMP_NONE, 3'b000, 3'b010});
        row(32'h30200073, IMM_CSR, 4'b0010, '0, MN, {CMP_NONE, 3'b000, 3'b001});
        row(enc(7'h18, 5'd0, 3'd1, OPC_SYSTEM), IMM_CSR, 4'b1010, '0, MN,
            {CMP_NONE, 3'b001, 3'b000});
        row(enc(7'h18, 5'd0, 3'd6, OPC_SYSTEM), IMM_CSR, 4'b0010, '0, MN,
            {CMP_NONE, 3'b110, 3'b000});
        row(enc(7'h00, 5'd0, 3'd0, 7'h7f), IMM_NONE, 4'b0000, '0, MN, SN);
        built = 1'b1;

        repeat (4) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        @(negedge clk_i);
        check_value("ctrl_valid_o after reset", 64'(ctrl_valid_o), 64'd0);

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk_i);
            #1;
            inst_valid_i = 1'b1;
            inst_i       = rows[i].inst;
            cur_exp      = rows[i].exp;
            cur_ret      = rows[i].ret;
            @(negedge clk_i);
            while (!inst_ready_o) @(negedge clk_i);
            // no credits come back until the buffer is full
            if (hold && i == DECODE_CREDITS - 1) begin
                repeat (3) begin
                    @(negedge clk_i);
                    if (inst_ready_o) begin
                        errors++;
                        $display("ERROR at %0t: ready stayed high with no credits left", $time);
                    end
                end
                hold = 1'b0;
            end
        end
        @(posedge clk_i);
        #1;
        inst_valid_i = 1'b0;
        cur_ret      = 1'b1;
        while (exp_q.size() != 0 || credits != DECODE_CREDITS) @(negedge clk_i);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
rtl/rv_decode_pkg.sv
rtl/opcode_classifier.sv
rtl/alu_field_decoder.sv
rtl/mem_field_decoder.sv
rtl/branch_sys_decoder.sv
rtl/decode_credit_ctrl.sv
rtl/rv_id_stage.sv
tests/rv_id_stage_assertions.sv
tests/tb_rv_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_rv_id_stage
FILELIST  := all.f

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST OK"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
